/* compile.f */
+incdir+verilog
verilog/fifo_data_pkg.sv
verilog/fifo_level_pkg.sv
verilog/fifo_bank.sv
verilog/push_rotator.sv
verilog/pop_rotator.sv
verilog/fifo_status.sv
verilog/fifo_4w2r.sv
tb/fifo_4w2r_tb.sv

/* run.sh */
#!/bin/sh
# Builds and runs the testbench, exit status is the simulation result
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal \
  -f compile.f \
  --top-module fifo_4w2r_tb \
  -o fifo_4w2r_sim
./obj_dir/fifo_4w2r_sim

/* tb/fifo_4w2r_tb.sv */
`timescale 1ns/1ps
`include "fifo_params.svh"

module fifo_4w2r_tb
  import fifo_data_pkg::*, fifo_level_pkg::*;
;

  localparam int DEPTH = `FIFO_BANKS * `FIFO_BANK_DEPTH;
  localparam int TIMEOUT_CYCLES = 3000;

  typedef struct packed {
    data_t       out0;
    data_t       out1;
    logic        full;
    logic        empty;
    logic        half_full;
    fifo_level_t room;
    fifo_level_t avail;
  } expect_t;

  logic        clk;
  logic        reset;
  logic        push0, push1, push2, push3;
  data_t       in_data0, in_data1, in_data2, in_data3;
  logic        pop0, pop1;
  data_t       out_data0, out_data1;
  logic        full, empty, half_full;
  fifo_level_t room, avail;

  // Entries the DUT should hold in order from the oldest
  data_t       model_q[$];
  int          pend_push;
  int          pend_pop;
  data_t       pend_data [4];
  logic [15:0] lfsr_state = 16'd13;
  logic [15:0] seq = 16'd0;
  int          cycle_count = 0;
  int          n_push;
  int          n_pop;
  data_t       first0, first1;

  fifo_4w2r UUT (
    .clk (clk), .reset (reset),
    .push0 (push0), .push1 (push1), .push2 (push2), .push3 (push3),
    .in_data0 (in_data0), .in_data1 (in_data1), .in_data2 (in_data2), .in_data3 (in_data3),
    .pop0 (pop0), .pop1 (pop1),
    .out_data0 (out_data0), .out_data1 (out_data1),
    .full (full), .empty (empty), .half_full (half_full), .room (room), .avail (avail)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] r;
    logic        lsb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lsb = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (lsb) lfsr_state = lfsr_state ^ 16'hB400;
      r = {r[30:0], lsb};
    end
    return r;
  endfunction

  function automatic int min_int(input int a, input int b);
    return (a < b) ? a : b;
  endfunction

  // Expected outputs from the queue model
  function automatic expect_t model_expect();
    expect_t e;
    int      n;
    n = model_q.size();
    e.avail     = fifo_level_t'(n);
    e.room      = fifo_level_t'(DEPTH - n);
    e.full      = (n == DEPTH);
    e.empty     = (n == 0);
    e.half_full = (n >= DEPTH / 2);
    e.out0      = (n >= 1) ? model_q[0] : '0;
    e.out1      = (n >= 2) ? model_q[1] : '0;
    return e;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
      $display("STATUS: FAIL");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic compare_outputs();
    expect_t e;
    e = model_expect();
    check_value("avail", 32'(e.avail), 32'(avail));
    check_value("room", 32'(e.room), 32'(room));
    check_value("full", 32'(e.full), 32'(full));
    check_value("empty", 32'(e.empty), 32'(empty));
    check_value("half_full", 32'(e.half_full), 32'(half_full));
    if (e.avail >= 1) check_value("out_data0", e.out0, out_data0);
    if (e.avail >= 2) check_value("out_data1", e.out1, out_data1);
  endtask

  // Ops driven at the last edge are taken by the DUT at this one
  task automatic next_edge();
    @(posedge clk);
    for (int i = 0; i < pend_pop; i++) void'(model_q.pop_front());
    for (int i = 0; i < pend_push; i++) model_q.push_back(pend_data[i]);
  endtask

  task automatic drive_ops(input int np, input int npop);
    logic [31:0] r;
    for (int i = 0; i < 4; i++) begin
      pend_data[i] = '0;
      if (i < np) begin
        r = random_bits(16);
        pend_data[i] = {r[15:0], seq};
        seq = seq + 16'd1;
      end
    end
    pend_push = np;
    pend_pop = npop;
    push0 <= (np > 0);
    push1 <= (np > 1);
    push2 <= (np > 2);
    push3 <= (np > 3);
    in_data0 <= pend_data[0];
    in_data1 <= pend_data[1];
    in_data2 <= pend_data[2];
    in_data3 <= pend_data[3];
    pop0 <= (npop > 0);
    pop1 <= (npop > 1);
  endtask

  // Outputs are stable by the falling edge
  always @(negedge clk) begin
    if (reset === 1'b0) compare_outputs();
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("STATUS: FAIL");
      $fatal(1, "timeout");
    end
  end

  initial begin
    reset = 1'b1;
    {push0, push1, push2, push3, pop0, pop1} = '0;
    {in_data0, in_data1, in_data2, in_data3} = '0;
    pend_push = 0;
    pend_pop = 0;
    repeat (5) @(posedge clk);
    reset <= 1'b0;

    // Fill with four wide pushes
    for (int c = 0; c < 4; c++) begin
      next_edge();
      drive_ops(4, 0);
      if (c == 0) begin
        first0 = pend_data[0];
        first1 = pend_data[1];
      end
    end
    next_edge();
    drive_ops(0, 0);
    @(negedge clk);
    check_value("full", 32'd1, 32'(full));
    check_value("room", 32'd0, 32'(room));
    check_value("half_full", 32'd1, 32'(half_full));
    check_value("out_data0", first0, out_data0);
    check_value("out_data1", first1, out_data1);

    // Drain two at a time
    repeat (9) begin
      next_edge();
      drive_ops(0, min_int(2, model_q.size()));
    end
    @(negedge clk);
    check_value("empty", 32'd1, 32'(empty));

    // Single lanes walk both start registers around
    repeat (6) begin
      next_edge();
      drive_ops(1, 0);
    end
    repeat (16) begin
      next_edge();
      drive_ops(1, min_int(1, model_q.size()));
    end
    repeat (8) begin
      next_edge();
      drive_ops(0, min_int(1, model_q.size()));
    end

    repeat (2000) begin
      next_edge();
      n_push = int'(random_bits(3)) % (min_int(4, DEPTH - model_q.size()) + 1);
      n_pop = int'(random_bits(2)) % (min_int(2, model_q.size()) + 1);
      drive_ops(n_push, n_pop);
    end

    repeat (10) begin
      next_edge();
      drive_ops(0, min_int(2, model_q.size()));
    end
    @(negedge clk);
    check_value("empty", 32'd1, 32'(empty));

    $display("STATUS: PASS");
    $finish;
  end

endmodule

/* verilog/fifo_4w2r.sv */
`timescale 1ns/1ps
`include "fifo_params.svh"

module fifo_4w2r
  import fifo_data_pkg::*, fifo_level_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic        push0,
  input  logic        push1,
  input  logic        push2,
  input  logic        push3,
  input  data_t       in_data0,
  input  data_t       in_data1,
  input  data_t       in_data2,
  input  data_t       in_data3,
  input  logic        pop0,
  input  logic        pop1,
  output data_t       out_data0,
  output data_t       out_data1,
  output logic        full,
  output logic        empty,
  output logic        half_full,
  output fifo_level_t room,
  output fifo_level_t avail
);

  logic [`FIFO_BANKS-1:0] bank_push;
  logic [`FIFO_BANKS-1:0] bank_pop;
  data_t                  bank_in_data [`FIFO_BANKS];
  data_t                  bank_out_data [`FIFO_BANKS];
  bank_level_t            bank_level [`FIFO_BANKS];

  push_rotator u_push_rotator (
    .clk          (clk),
    .reset        (reset),
    .push0        (push0),
    .push1        (push1),
    .push2        (push2),
    .push3        (push3),
    .in_data0     (in_data0),
    .in_data1     (in_data1),
    .in_data2     (in_data2),
    .in_data3     (in_data3),
    .bank_push    (bank_push),
    .bank_in_data (bank_in_data)
  );

  // Bank k holds entries k, k+4, k+8 ... relative to the start
  fifo_bank bank0 (
    .clk (clk), .reset (reset), .push (bank_push[0]), .in_data (bank_in_data[0]),
    .pop (bank_pop[0]), .out_data (bank_out_data[0]), .level (bank_level[0])
  );
  fifo_bank bank1 (
    .clk (clk), .reset (reset), .push (bank_push[1]), .in_data (bank_in_data[1]),
    .pop (bank_pop[1]), .out_data (bank_out_data[1]), .level (bank_level[1])
  );
  fifo_bank bank2 (
    .clk (clk), .reset (reset), .push (bank_push[2]), .in_data (bank_in_data[2]),
    .pop (bank_pop[2]), .out_data (bank_out_data[2]), .level (bank_level[2])
  );
  fifo_bank bank3 (
    .clk (clk), .reset (reset), .push (bank_push[3]), .in_data (bank_in_data[3]),
    .pop (bank_pop[3]), .out_data (bank_out_data[3]), .level (bank_level[3])
  );

  pop_rotator u_pop_rotator (
    .clk           (clk),
    .reset         (reset),
    .pop0          (pop0),
    .pop1          (pop1),
    .bank_out_data (bank_out_data),
    .bank_pop      (bank_pop),
    .out_data0     (out_data0),
    .out_data1     (out_data1)
  );

  fifo_status u_status (
    .level0    (bank_level[0]),
    .level1    (bank_level[1]),
    .level2    (bank_level[2]),
    .level3    (bank_level[3]),
    .full      (full),
    .empty     (empty),
    .half_full (half_full),
    .room      (room),
    .avail     (avail)
  );

endmodule

/* verilog/fifo_bank.sv */
`timescale 1ns/1ps
`include "fifo_params.svh"

module fifo_bank
  import fifo_data_pkg::*, fifo_level_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic        push,
  input  data_t       in_data,
  input  logic        pop,
  output data_t       out_data,
  output bank_level_t level
);

  localparam int PTR_W = $clog2(`FIFO_BANK_DEPTH);

  data_t             mem [`FIFO_BANK_DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;

  // Storage written at the tail
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      level  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10: level <= level + 1'b1;
        2'b01: level <= level - 1'b1;
        default: level <= level;
      endcase
    end
  end

  // Head is visible without a read cycle
  assign out_data = mem[rd_ptr];

  // A full bank only takes a new entry while its head leaves
  a_no_overflow: assert property (
    @(posedge clk) disable iff (reset)
    (push && level == bank_level_t'(`FIFO_BANK_DEPTH)) |-> pop
  ) else $error("fifo_bank: push into full bank");

  // Pop only when something is stored
  a_no_underflow: assert property (
    @(posedge clk) disable iff (reset)
    pop |-> level != '0
  ) else $error("fifo_bank: pop from empty bank");

endmodule

/* verilog/fifo_data_pkg.sv */
`include "fifo_params.svh"

package fifo_data_pkg;

  // One stored entry
  typedef logic [`FIFO_DWIDTH-1:0] data_t;

  // Selects one of the banks
  typedef logic [$clog2(`FIFO_BANKS)-1:0] bank_sel_t;

  // Lane enables with lane 0 the oldest
  typedef logic [`FIFO_PUSH_LANES-1:0] push_lanes_t;
  typedef logic [`FIFO_POP_LANES-1:0] pop_lanes_t;

endpackage

/* verilog/fifo_level_pkg.sv */
`include "fifo_params.svh"

package fifo_level_pkg;

  // Occupancy of a single bank from 0 up to the full depth
  typedef logic [$clog2(`FIFO_BANK_DEPTH+1)-1:0] bank_level_t;

  // Occupancy or free space of the whole FIFO
  typedef logic [$clog2(`FIFO_BANKS*`FIFO_BANK_DEPTH+1)-1:0] fifo_level_t;

endpackage

/* verilog/fifo_params.svh */
`ifndef FIFO_PARAMS_SVH
`define FIFO_PARAMS_SVH

// Width of one entry
`define FIFO_DWIDTH 32

// Storage is split into interleaved banks
`define FIFO_BANKS 4
`define FIFO_BANK_DEPTH 4

// Lanes per clock on each side
`define FIFO_PUSH_LANES 4
`define FIFO_POP_LANES 2

`endif

/* verilog/fifo_status.sv */
`timescale 1ns/1ps
`include "fifo_params.svh"

module fifo_status
  import fifo_level_pkg::*;
(
  input  bank_level_t level0,
  input  bank_level_t level1,
  input  bank_level_t level2,
  input  bank_level_t level3,
  output logic        full,
  output logic        empty,
  output logic        half_full,
  output fifo_level_t room,
  output fifo_level_t avail
);

  localparam int DEPTH = `FIFO_BANKS * `FIFO_BANK_DEPTH;

  // Whole FIFO occupancy from the four banks
  assign avail = fifo_level_t'(level0) + fifo_level_t'(level1)
               + fifo_level_t'(level2) + fifo_level_t'(level3);

  assign room = fifo_level_t'(DEPTH) - avail;

  assign full      = (avail == fifo_level_t'(DEPTH));
  assign empty     = (avail == '0);
  assign half_full = (avail >= fifo_level_t'(DEPTH / 2));

endmodule

/* verilog/pop_rotator.sv */
`timescale 1ns/1ps
`include "fifo_params.svh"

module pop_rotator
  import fifo_data_pkg::*;
(
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   pop0,
  input  logic                   pop1,
  input  data_t                  bank_out_data [`FIFO_BANKS],
  output logic [`FIFO_BANKS-1:0] bank_pop,
  output data_t                  out_data0,
  output data_t                  out_data1
);

  bank_sel_t  start;
  pop_lanes_t pops;
  logic [1:0] pop_cnt;

  assign pops = {pop1, pop0};
  assign pop_cnt = 2'(pop0) + 2'(pop1);

  // Only the start bank and the one after it can be popped
  always_comb begin
    bank_sel_t lane;
    for (int b = 0; b < `FIFO_BANKS; b++) begin
      lane = bank_sel_t'(b) - start;
      bank_pop[b] = (lane < `FIFO_POP_LANES) && pops[lane[0]];
    end
  end

  // Oldest entry sits in the start bank
  assign out_data0 = bank_out_data[start];
  assign out_data1 = bank_out_data[bank_sel_t'(start + 1'b1)];

  always_ff @(posedge clk) begin
    if (reset) begin
      start <= '0;
    end else begin
      start <= start + bank_sel_t'(pop_cnt);
    end
  end

  // Second lane never pops on its own
  a_pop_order: assert property (
    @(posedge clk) disable iff (reset)
    pop1 |-> pop0
  ) else $error("pop_rotator: pop1 without pop0");

endmodule

/* verilog/push_rotator.sv */
`timescale 1ns/1ps
`include "fifo_params.svh"

module push_rotator
  import fifo_data_pkg::*;
(
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   push0,
  input  logic                   push1,
  input  logic                   push2,
  input  logic                   push3,
  input  data_t                  in_data0,
  input  data_t                  in_data1,
  input  data_t                  in_data2,
  input  data_t                  in_data3,
  output logic [`FIFO_BANKS-1:0] bank_push,
  output data_t                  bank_in_data [`FIFO_BANKS]
);

  bank_sel_t   start;
  push_lanes_t lanes;
  data_t       lane_data [`FIFO_PUSH_LANES];
  logic [2:0]  push_cnt;

  assign lanes = {push3, push2, push1, push0};
  assign lane_data[0] = in_data0;
  assign lane_data[1] = in_data1;
  assign lane_data[2] = in_data2;
  assign lane_data[3] = in_data3;

  assign push_cnt = 3'(push0) + 3'(push1) + 3'(push2) + 3'(push3);

  // Bank b takes lane (b - start) mod 4
  always_comb begin
    bank_sel_t lane;
    for (int b = 0; b < `FIFO_BANKS; b++) begin
      lane = bank_sel_t'(b) - start;
      bank_push[b] = lanes[lane];
      bank_in_data[b] = lane_data[lane];
    end
  end

  // Next new entry lands after the ones written now
  always_ff @(posedge clk) begin
    if (reset) begin
      start <= '0;
    end else begin
      start <= start + bank_sel_t'(push_cnt);
    end
  end

  // Only none, 0, 0-1, 0-2 or 0-3 are legal
  a_push_contiguous: assert property (
    @(posedge clk) disable iff (reset)
    ((lanes + 1'b1) & lanes) == '0
  ) else $error("push_rotator: push lanes not contiguous from lane 0");

endmodule
